//--- logic/axil_xbar_pkg.sv
package axil_xbar_pkg;

  // number of managers feeding each arbiter
  localparam int NUM_MGR = 3;

  // write address, even goes to subordinate 0 and odd to subordinate 1
  typedef logic [19:0] addr_t;

  // write data and its byte strobes
  typedef logic [15:0] data_t;
  typedef logic [1:0] strb_t;

  // axi response code, passed through untouched
  typedef logic [1:0] resp_t;

  // manager index, 0 to 2 name a manager
  typedef logic [1:0] mgr_idx_t;

  // grant code for no manager
  localparam mgr_idx_t MGR_IDLE = 2'd3;

endpackage

//--- logic/axil_write_if.sv
`timescale 1ns/1ps

// one axi-lite write channel, aw + w + b
interface axil_write_if;

  // address phase
  axil_xbar_pkg::addr_t awaddr;
  logic awvalid;
  logic awready;

  // data phase
  axil_xbar_pkg::data_t wdata;
  axil_xbar_pkg::strb_t wstrb;
  logic wvalid;
  logic wready;

  // response phase
  axil_xbar_pkg::resp_t bresp;
  logic bvalid;
  logic bready;

  // seen from the side that issues writes
  modport mgr (
    output awaddr, awvalid, wdata, wstrb, wvalid, bready,
    input awready, wready, bresp, bvalid
  );

  // seen from the side that answers writes
  modport sub (
    input awaddr, awvalid, wdata, wstrb, wvalid, bready,
    output awready, wready, bresp, bvalid
  );

endinterface

//--- logic/resp_order_fifo.sv
`timescale 1ns/1ps

module resp_order_fifo #(
  parameter int FIFO_AW = 3
) (
  input logic axi_clk,
  input logic axi_resetn,
  input logic push,
  input axil_xbar_pkg::mgr_idx_t push_idx,
  input logic pop,
  output axil_xbar_pkg::mgr_idx_t head_idx,
  output logic empty,
  output logic full
);

  localparam int DEPTH = 1 << FIFO_AW;

  axil_xbar_pkg::mgr_idx_t mem [DEPTH];

  // extra msb tells a wrapped write pointer from an equal one
  logic [FIFO_AW:0] wr_ptr;
  logic [FIFO_AW:0] rd_ptr;
  logic do_push;
  logic do_pop;

  // pop on empty is dropped, push on full as well
  assign do_push = push & ~full;
  assign do_pop = pop & ~empty;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (do_push) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= push_idx;
    end
  end

  // head only meaningful while not empty
  assign head_idx = mem[rd_ptr[FIFO_AW-1:0]];
  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

endmodule

//--- logic/write_channel_arb.sv
`timescale 1ns/1ps

module write_channel_arb #(
  parameter int SUB_SEL = 0,
  parameter int FIFO_AW = 3
) (
  input logic axi_clk,
  input logic axi_resetn,
  axil_write_if.sub m0,
  axil_write_if.sub m1,
  axil_write_if.sub m2,
  axil_write_if.mgr s,
  output logic [axil_xbar_pkg::NUM_MGR-1:0] awready_out,
  output logic [axil_xbar_pkg::NUM_MGR-1:0] wready_out,
  output logic [axil_xbar_pkg::NUM_MGR-1:0] bvalid_out,
  output axil_xbar_pkg::resp_t bresp_out
);

  localparam int N = axil_xbar_pkg::NUM_MGR;

  // manager signals gathered so the grant can index them
  // slot 3 is the idle code and stays zero
  axil_xbar_pkg::addr_t all_awaddr [4];
  axil_xbar_pkg::data_t all_wdata [4];
  axil_xbar_pkg::strb_t all_wstrb [4];
  logic [3:0] all_awvalid;
  logic [3:0] all_wvalid;
  logic [3:0] all_bready;
  logic [3:0] greq;

  axil_xbar_pkg::mgr_idx_t grant_q;
  axil_xbar_pkg::mgr_idx_t grant_d;
  axil_xbar_pkg::mgr_idx_t head_idx;
  axil_xbar_pkg::mgr_idx_t resp_idx;
  logic idle;

  logic aw_done_q;
  logic w_done_q;
  logic aw_ok;
  logic w_ok;
  logic aw_hs;
  logic w_hs;
  logic accepted;
  logic fifo_empty;
  logic fifo_full;
  logic b_hs;

  assign all_awaddr[0] = m0.awaddr;
  assign all_awaddr[1] = m1.awaddr;
  assign all_awaddr[2] = m2.awaddr;
  assign all_awaddr[3] = '0;
  assign all_wdata[0] = m0.wdata;
  assign all_wdata[1] = m1.wdata;
  assign all_wdata[2] = m2.wdata;
  assign all_wdata[3] = '0;
  assign all_wstrb[0] = m0.wstrb;
  assign all_wstrb[1] = m1.wstrb;
  assign all_wstrb[2] = m2.wstrb;
  assign all_wstrb[3] = '0;
  assign all_awvalid = {1'b0, m2.awvalid, m1.awvalid, m0.awvalid};
  assign all_wvalid = {1'b0, m2.wvalid, m1.wvalid, m0.wvalid};
  assign all_bready = {1'b0, m2.bready, m1.bready, m0.bready};

  // request only when the address parity selects this subordinate
  always_comb begin
    greq = '0;
    for (int i = 0; i < N; i++) begin
      greq[i] = all_awvalid[i] && (all_awaddr[i][0] == 1'(SUB_SEL));
    end
  end

  assign idle = (grant_q == axil_xbar_pkg::MGR_IDLE);

  // aw and w pass only while their half is still open
  // a full fifo holds both back
  assign aw_ok = greq[grant_q] & ~aw_done_q & ~fifo_full;
  assign w_ok = all_wvalid[grant_q] & ~w_done_q & ~fifo_full;
  assign aw_hs = aw_ok & s.awready;
  assign w_hs = w_ok & s.wready;

  // accepted once both halves are in, earlier half comes from the flag
  assign accepted = (aw_done_q | aw_hs) & (w_done_q | w_hs);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      aw_done_q <= 1'b0;
      w_done_q <= 1'b0;
    end else if (accepted) begin
      aw_done_q <= 1'b0;
      w_done_q <= 1'b0;
    end else begin
      aw_done_q <= aw_done_q | aw_hs;
      w_done_q <= w_done_q | w_hs;
    end
  end

  // next grant, holder masked so another waiter wins
  always_comb begin
    logic [3:0] masked;
    masked = greq;
    grant_d = grant_q;
    if (!idle) begin
      masked[grant_q] = 1'b0;
    end
    if (idle || accepted) begin
      if (masked[0]) begin
        grant_d = 2'd0;
      end else if (masked[1]) begin
        grant_d = 2'd1;
      end else if (masked[2]) begin
        grant_d = 2'd2;
      end else if (!idle && greq[grant_q] && aw_done_q) begin
        // holder already shows its next aw, skip the idle bubble
        // without aw_done_q the aw on the bus is the one just accepted
        grant_d = grant_q;
      end else begin
        grant_d = axil_xbar_pkg::MGR_IDLE;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      grant_q <= axil_xbar_pkg::MGR_IDLE;
    end else begin
      grant_q <= grant_d;
    end
  end

  // aw and w mux toward the subordinate
  assign s.awaddr = all_awaddr[grant_q];
  assign s.awvalid = aw_ok;
  assign s.wdata = all_wdata[grant_q];
  assign s.wstrb = all_wstrb[grant_q];
  assign s.wvalid = w_ok;

  // owner of each outstanding b, oldest at the head
  resp_order_fifo #(
    .FIFO_AW(FIFO_AW)
  ) u_resp_fifo (
    .axi_clk(axi_clk),
    .axi_resetn(axi_resetn),
    .push(accepted),
    .push_idx(grant_q),
    .pop(b_hs),
    .head_idx(head_idx),
    .empty(fifo_empty),
    .full(fifo_full)
  );

  assign resp_idx = fifo_empty ? axil_xbar_pkg::MGR_IDLE : head_idx;
  assign s.bready = all_bready[resp_idx];
  assign b_hs = s.bvalid & s.bready;
  assign bresp_out = s.bresp;

  // per manager readies and bvalid, only the served one sees anything
  always_comb begin
    for (int i = 0; i < N; i++) begin
      awready_out[i] = (grant_q == i) && aw_hs;
      wready_out[i] = (grant_q == i) && w_hs;
      bvalid_out[i] = (resp_idx == i) && s.bvalid;
    end
  end

endmodule

//--- logic/axil_write_xbar.sv
`timescale 1ns/1ps

module axil_write_xbar (
  input logic axi_clk,
  input logic axi_resetn,
  input axil_xbar_pkg::addr_t in0_awaddr,
  input logic in0_awvalid,
  output logic in0_awready,
  input axil_xbar_pkg::data_t in0_wdata,
  input axil_xbar_pkg::strb_t in0_wstrb,
  input logic in0_wvalid,
  output logic in0_wready,
  output axil_xbar_pkg::resp_t in0_bresp,
  output logic in0_bvalid,
  input logic in0_bready,
  input axil_xbar_pkg::addr_t in1_awaddr,
  input logic in1_awvalid,
  output logic in1_awready,
  input axil_xbar_pkg::data_t in1_wdata,
  input axil_xbar_pkg::strb_t in1_wstrb,
  input logic in1_wvalid,
  output logic in1_wready,
  output axil_xbar_pkg::resp_t in1_bresp,
  output logic in1_bvalid,
  input logic in1_bready,
  input axil_xbar_pkg::addr_t in2_awaddr,
  input logic in2_awvalid,
  output logic in2_awready,
  input axil_xbar_pkg::data_t in2_wdata,
  input axil_xbar_pkg::strb_t in2_wstrb,
  input logic in2_wvalid,
  output logic in2_wready,
  output axil_xbar_pkg::resp_t in2_bresp,
  output logic in2_bvalid,
  input logic in2_bready,
  output axil_xbar_pkg::addr_t out0_awaddr,
  output logic out0_awvalid,
  input logic out0_awready,
  output axil_xbar_pkg::data_t out0_wdata,
  output axil_xbar_pkg::strb_t out0_wstrb,
  output logic out0_wvalid,
  input logic out0_wready,
  input axil_xbar_pkg::resp_t out0_bresp,
  input logic out0_bvalid,
  output logic out0_bready,
  output axil_xbar_pkg::addr_t out1_awaddr,
  output logic out1_awvalid,
  input logic out1_awready,
  output axil_xbar_pkg::data_t out1_wdata,
  output axil_xbar_pkg::strb_t out1_wstrb,
  output logic out1_wvalid,
  input logic out1_wready,
  input axil_xbar_pkg::resp_t out1_bresp,
  input logic out1_bvalid,
  output logic out1_bready
);

  localparam int N = axil_xbar_pkg::NUM_MGR;

  // per manager outputs of the two arbiters, merged below
  logic [N-1:0] a0_awready;
  logic [N-1:0] a0_wready;
  logic [N-1:0] a0_bvalid;
  logic [N-1:0] a1_awready;
  logic [N-1:0] a1_wready;
  logic [N-1:0] a1_bvalid;
  axil_xbar_pkg::resp_t a0_bresp;
  axil_xbar_pkg::resp_t a1_bresp;

  axil_write_if m0 ();
  axil_write_if m1 ();
  axil_write_if m2 ();
  axil_write_if s0 ();
  axil_write_if s1 ();

  // manager 0
  assign m0.awaddr = in0_awaddr;
  assign m0.awvalid = in0_awvalid;
  assign m0.wdata = in0_wdata;
  assign m0.wstrb = in0_wstrb;
  assign m0.wvalid = in0_wvalid;
  assign m0.bready = in0_bready;
  // an arbiter drives a bit only for the manager it serves, so or is enough
  assign m0.awready = a0_awready[0] | a1_awready[0];
  assign m0.wready = a0_wready[0] | a1_wready[0];
  assign m0.bvalid = a0_bvalid[0] | a1_bvalid[0];
  assign m0.bresp = a1_bvalid[0] ? a1_bresp : a0_bresp;
  assign in0_awready = m0.awready;
  assign in0_wready = m0.wready;
  assign in0_bvalid = m0.bvalid;
  assign in0_bresp = m0.bresp;

  // manager 1
  assign m1.awaddr = in1_awaddr;
  assign m1.awvalid = in1_awvalid;
  assign m1.wdata = in1_wdata;
  assign m1.wstrb = in1_wstrb;
  assign m1.wvalid = in1_wvalid;
  assign m1.bready = in1_bready;
  assign m1.awready = a0_awready[1] | a1_awready[1];
  assign m1.wready = a0_wready[1] | a1_wready[1];
  assign m1.bvalid = a0_bvalid[1] | a1_bvalid[1];
  assign m1.bresp = a1_bvalid[1] ? a1_bresp : a0_bresp;
  assign in1_awready = m1.awready;
  assign in1_wready = m1.wready;
  assign in1_bvalid = m1.bvalid;
  assign in1_bresp = m1.bresp;

  // manager 2
  assign m2.awaddr = in2_awaddr;
  assign m2.awvalid = in2_awvalid;
  assign m2.wdata = in2_wdata;
  assign m2.wstrb = in2_wstrb;
  assign m2.wvalid = in2_wvalid;
  assign m2.bready = in2_bready;
  assign m2.awready = a0_awready[2] | a1_awready[2];
  assign m2.wready = a0_wready[2] | a1_wready[2];
  assign m2.bvalid = a0_bvalid[2] | a1_bvalid[2];
  assign m2.bresp = a1_bvalid[2] ? a1_bresp : a0_bresp;
  assign in2_awready = m2.awready;
  assign in2_wready = m2.wready;
  assign in2_bvalid = m2.bvalid;
  assign in2_bresp = m2.bresp;

  // subordinate 0, even addresses
  assign out0_awaddr = s0.awaddr;
  assign out0_awvalid = s0.awvalid;
  assign out0_wdata = s0.wdata;
  assign out0_wstrb = s0.wstrb;
  assign out0_wvalid = s0.wvalid;
  assign out0_bready = s0.bready;
  assign s0.awready = out0_awready;
  assign s0.wready = out0_wready;
  assign s0.bresp = out0_bresp;
  assign s0.bvalid = out0_bvalid;

  // subordinate 1, odd addresses
  assign out1_awaddr = s1.awaddr;
  assign out1_awvalid = s1.awvalid;
  assign out1_wdata = s1.wdata;
  assign out1_wstrb = s1.wstrb;
  assign out1_wvalid = s1.wvalid;
  assign out1_bready = s1.bready;
  assign s1.awready = out1_awready;
  assign s1.wready = out1_wready;
  assign s1.bresp = out1_bresp;
  assign s1.bvalid = out1_bvalid;

  write_channel_arb #(
    .SUB_SEL(0),
    .FIFO_AW(3)
  ) arb0 (
    .axi_clk(axi_clk),
    .axi_resetn(axi_resetn),
    .m0(m0.sub),
    .m1(m1.sub),
    .m2(m2.sub),
    .s(s0.mgr),
    .awready_out(a0_awready),
    .wready_out(a0_wready),
    .bvalid_out(a0_bvalid),
    .bresp_out(a0_bresp)
  );

  write_channel_arb #(
    .SUB_SEL(1),
    .FIFO_AW(3)
  ) arb1 (
    .axi_clk(axi_clk),
    .axi_resetn(axi_resetn),
    .m0(m0.sub),
    .m1(m1.sub),
    .m2(m2.sub),
    .s(s1.mgr),
    .awready_out(a1_awready),
    .wready_out(a1_wready),
    .bvalid_out(a1_bvalid),
    .bresp_out(a1_bresp)
  );

endmodule

//--- bench/axil_write_xbar_chk.sv
`timescale 1ns/1ps

// protocol checks on the crossbar ports, bound into the top
module axil_write_xbar_chk (
  input logic axi_clk,
  input logic axi_resetn,
  input axil_xbar_pkg::addr_t in0_awaddr,
  input logic in0_awvalid,
  input logic in0_awready,
  input logic in0_wready,
  input logic in0_bvalid,
  input axil_xbar_pkg::addr_t in1_awaddr,
  input logic in1_awvalid,
  input logic in1_awready,
  input logic in1_wready,
  input logic in1_bvalid,
  input axil_xbar_pkg::addr_t in2_awaddr,
  input logic in2_awvalid,
  input logic in2_awready,
  input logic in2_wready,
  input logic in2_bvalid,
  input axil_xbar_pkg::addr_t out0_awaddr,
  input logic out0_awvalid,
  input logic out0_awready,
  input axil_xbar_pkg::data_t out0_wdata,
  input axil_xbar_pkg::strb_t out0_wstrb,
  input logic out0_wvalid,
  input logic out0_wready,
  input logic out0_bready,
  input axil_xbar_pkg::addr_t out1_awaddr,
  input logic out1_awvalid,
  input logic out1_awready,
  input axil_xbar_pkg::data_t out1_wdata,
  input axil_xbar_pkg::strb_t out1_wstrb,
  input logic out1_wvalid,
  input logic out1_wready,
  input logic out1_bready
);

  logic quiet;
  axil_xbar_pkg::addr_t addr [3];
  logic [2:0] vld;
  logic [2:0] hs;
  logic [1:0] others [3];
  logic [2:0] waited [3];

  // every valid and ready the crossbar drives
  assign quiet = ~|{out0_awvalid, out0_wvalid, out0_bready,
                    out1_awvalid, out1_wvalid, out1_bready,
                    in0_awready, in0_wready, in0_bvalid,
                    in1_awready, in1_wready, in1_bvalid,
                    in2_awready, in2_wready, in2_bvalid};

  assign addr[0] = in0_awaddr;
  assign addr[1] = in1_awaddr;
  assign addr[2] = in2_awaddr;
  assign vld = {in2_awvalid, in1_awvalid, in0_awvalid};
  assign hs = vld & {in2_awready, in1_awready, in0_awready};

  // aw beats of other managers to the same subordinate this cycle
  always_comb begin
    for (int m = 0; m < 3; m++) begin
      others[m] = '0;
      for (int k = 0; k < 3; k++) begin
        if (k != m && hs[k] && addr[k][0] == addr[m][0]) begin
          others[m] = others[m] + 2'd1;
        end
      end
    end
  end

  // passed-over count while a manager requests, saturates above the bound
  always_ff @(posedge axi_clk) begin
    for (int m = 0; m < 3; m++) begin
      if (!axi_resetn || !vld[m] || hs[m]) begin
        waited[m] <= '0;
      end else if (waited[m] < 3'd6) begin
        waited[m] <= waited[m] + 3'(others[m]);
      end
    end
  end

  assert property (@(posedge axi_clk) !axi_resetn |-> quiet)
    else $error("valid or ready high during reset");
  assert property (@(posedge axi_clk) $rose(axi_resetn) |-> quiet)
    else $error("valid or ready high right after reset");

  // parity routing
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    out0_awvalid |-> !out0_awaddr[0])
    else $error("odd address on out0");
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    out1_awvalid |-> out1_awaddr[0])
    else $error("even address on out1");

  // valid held with stable payload until taken
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    out0_awvalid && !out0_awready |=> out0_awvalid && $stable(out0_awaddr))
    else $error("out0 aw dropped or changed before ready");
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    out0_wvalid && !out0_wready |=> out0_wvalid && $stable({out0_wdata, out0_wstrb}))
    else $error("out0 w dropped or changed before ready");
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    out1_awvalid && !out1_awready |=> out1_awvalid && $stable(out1_awaddr))
    else $error("out1 aw dropped or changed before ready");
  assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    out1_wvalid && !out1_wready |=> out1_wvalid && $stable({out1_wdata, out1_wstrb}))
    else $error("out1 w dropped or changed before ready");

  // no manager passed over by more than two other writes
  assert property (@(posedge axi_clk) disable iff (!axi_resetn) waited[0] <= 3'd2)
    else $error("manager 0 starved");
  assert property (@(posedge axi_clk) disable iff (!axi_resetn) waited[1] <= 3'd2)
    else $error("manager 1 starved");
  assert property (@(posedge axi_clk) disable iff (!axi_resetn) waited[2] <= 3'd2)
    else $error("manager 2 starved");

endmodule

bind axil_write_xbar axil_write_xbar_chk chk (.*);

//--- bench/axil_write_xbar_tb.sv
`timescale 1ns/1ps

module axil_write_xbar_tb;

  logic axi_clk;
  logic axi_resetn;

  // manager side with one slot per manager
  axil_xbar_pkg::addr_t m_awaddr [3];
  axil_xbar_pkg::data_t m_wdata [3];
  axil_xbar_pkg::strb_t m_wstrb [3];
  axil_xbar_pkg::resp_t m_bresp [3];
  logic [2:0] m_awvalid;
  logic [2:0] m_awready;
  logic [2:0] m_wvalid;
  logic [2:0] m_wready;
  logic [2:0] m_bvalid;
  logic [2:0] m_bready;

  // subordinate side
  axil_xbar_pkg::addr_t s_awaddr [2];
  axil_xbar_pkg::data_t s_wdata [2];
  axil_xbar_pkg::strb_t s_wstrb [2];
  axil_xbar_pkg::resp_t s_bresp [2];
  logic [1:0] s_awvalid;
  logic [1:0] s_awready;
  logic [1:0] s_wvalid;
  logic [1:0] s_wready;
  logic [1:0] s_bvalid;
  logic [1:0] s_bready;

  integer seed = 32'h711d763d;
  int errors;
  int tests;
  int issued [3];
  int b_count [3];

  // manager side capture of accepted writes
  bit aw_seen [3];
  bit w_seen [3];
  axil_xbar_pkg::addr_t cap_addr [3];
  axil_xbar_pkg::data_t cap_data [3];
  axil_xbar_pkg::strb_t cap_strb [3];

  // scoreboard per subordinate holding {addr, data, strb}
  logic [37:0] exp_q [2][$];
  axil_xbar_pkg::addr_t s_aw_q [2][$];
  logic [17:0] s_w_q [2][$];
  axil_xbar_pkg::addr_t b_q [2][$];
  bit b_taken [2];
  int b_wait [2];
  int aw_stall [2];
  int w_stall [2];

  axil_write_xbar dut (
    .axi_clk(axi_clk), .axi_resetn(axi_resetn),
    .in0_awaddr(m_awaddr[0]), .in0_awvalid(m_awvalid[0]), .in0_awready(m_awready[0]),
    .in0_wdata(m_wdata[0]), .in0_wstrb(m_wstrb[0]), .in0_wvalid(m_wvalid[0]),
    .in0_wready(m_wready[0]), .in0_bresp(m_bresp[0]), .in0_bvalid(m_bvalid[0]),
    .in0_bready(m_bready[0]),
    .in1_awaddr(m_awaddr[1]), .in1_awvalid(m_awvalid[1]), .in1_awready(m_awready[1]),
    .in1_wdata(m_wdata[1]), .in1_wstrb(m_wstrb[1]), .in1_wvalid(m_wvalid[1]),
    .in1_wready(m_wready[1]), .in1_bresp(m_bresp[1]), .in1_bvalid(m_bvalid[1]),
    .in1_bready(m_bready[1]),
    .in2_awaddr(m_awaddr[2]), .in2_awvalid(m_awvalid[2]), .in2_awready(m_awready[2]),
    .in2_wdata(m_wdata[2]), .in2_wstrb(m_wstrb[2]), .in2_wvalid(m_wvalid[2]),
    .in2_wready(m_wready[2]), .in2_bresp(m_bresp[2]), .in2_bvalid(m_bvalid[2]),
    .in2_bready(m_bready[2]),
    .out0_awaddr(s_awaddr[0]), .out0_awvalid(s_awvalid[0]), .out0_awready(s_awready[0]),
    .out0_wdata(s_wdata[0]), .out0_wstrb(s_wstrb[0]), .out0_wvalid(s_wvalid[0]),
    .out0_wready(s_wready[0]), .out0_bresp(s_bresp[0]), .out0_bvalid(s_bvalid[0]),
    .out0_bready(s_bready[0]),
    .out1_awaddr(s_awaddr[1]), .out1_awvalid(s_awvalid[1]), .out1_awready(s_awready[1]),
    .out1_wdata(s_wdata[1]), .out1_wstrb(s_wstrb[1]), .out1_wvalid(s_wvalid[1]),
    .out1_wready(s_wready[1]), .out1_bresp(s_bresp[1]), .out1_bvalid(s_bvalid[1]),
    .out1_bready(s_bready[1])
  );

  always #4 axi_clk = ~axi_clk;

  task automatic give_up(input string what);
    $display("timeout: no progress on %s at %0t", what, $time);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // one write with aw and w raised after their own random delays
  task automatic write_one(input int m, input axil_xbar_pkg::addr_t addr,
                           input axil_xbar_pkg::data_t data, input axil_xbar_pkg::strb_t strb);
    int aw_wait;
    int w_wait;
    int cyc;
    bit aw_done;
    bit w_done;
    bit b_done;
    aw_wait = $unsigned($random(seed)) % 4;
    w_wait = $unsigned($random(seed)) % 4;
    cyc = 0;
    aw_done = 1'b0;
    w_done = 1'b0;
    b_done = 1'b0;
    while (!(aw_done && w_done)) begin
      @(negedge axi_clk);
      m_awaddr[m] = addr;
      m_wdata[m] = data;
      m_wstrb[m] = strb;
      m_awvalid[m] = !aw_done && (cyc >= aw_wait);
      m_wvalid[m] = !w_done && (cyc >= w_wait);
      @(posedge axi_clk);
      if (m_awvalid[m] && m_awready[m]) begin
        aw_done = 1'b1;
      end
      if (m_wvalid[m] && m_wready[m]) begin
        w_done = 1'b1;
      end
      cyc++;
      if (cyc > 200) begin
        give_up($sformatf("manager %0d aw/w", m));
      end
    end
    cyc = 0;
    while (!b_done) begin
      @(negedge axi_clk);
      m_awvalid[m] = 1'b0;
      m_wvalid[m] = 1'b0;
      m_bready[m] = 1'($random(seed));
      @(posedge axi_clk);
      if (m_bvalid[m] && m_bready[m]) begin
        b_done = 1'b1;
        assert (m_bresp[m] == addr[2:1]) else begin
          $display("FAIL %0t: manager %0d bresp %0d for address %h", $time, m,
                   m_bresp[m], addr);
          errors++;
        end
      end
      cyc++;
      if (cyc > 300) begin
        give_up($sformatf("manager %0d b response", m));
      end
    end
    @(negedge axi_clk);
    m_bready[m] = 1'b0;
  endtask

  // parity 0 means even addresses and 1 odd ones while 2 mixes both
  task automatic run_manager(input int m, input int count, input int parity);
    axil_xbar_pkg::addr_t addr;
    for (int i = 0; i < count; i++) begin
      addr = 20'($random(seed));
      if (parity < 2) begin
        addr[0] = 1'(parity);
      end
      issued[m]++;
      write_one(m, addr, 16'($random(seed)), 2'($random(seed)));
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    for (int m = 0; m < 3; m++) begin
      assert (b_count[m] == issued[m]) else begin
        $display("FAIL %0t: manager %0d got %0d responses for %0d writes", $time, m,
                 b_count[m], issued[m]);
        errors++;
      end
    end
    for (int s = 0; s < 2; s++) begin
      assert (exp_q[s].size() == 0) else begin
        $display("FAIL %0t: %0d writes never reached out%0d", $time, exp_q[s].size(), s);
        errors++;
      end
    end
    tests++;
    $display("test %s: %0d errors", name, errors - errors_before);
  endtask

  // handshake monitor that handles the manager side first so expectations exist before pairing
  always @(posedge axi_clk) begin
    logic [37:0] got;
    axil_xbar_pkg::addr_t a;
    logic [17:0] w;
    if (axi_resetn) begin
      for (int m = 0; m < 3; m++) begin
        if (m_awvalid[m] && m_awready[m]) begin
          aw_seen[m] = 1'b1;
          cap_addr[m] = m_awaddr[m];
        end
        if (m_wvalid[m] && m_wready[m]) begin
          w_seen[m] = 1'b1;
          cap_data[m] = m_wdata[m];
          cap_strb[m] = m_wstrb[m];
        end
        if (aw_seen[m] && w_seen[m]) begin
          exp_q[cap_addr[m][0]].push_back({cap_addr[m], cap_data[m], cap_strb[m]});
          aw_seen[m] = 1'b0;
          w_seen[m] = 1'b0;
        end
        if (m_bvalid[m] && m_bready[m]) begin
          b_count[m]++;
        end
      end
      for (int s = 0; s < 2; s++) begin
        if (s_awvalid[s] && s_awready[s]) begin
          s_aw_q[s].push_back(s_awaddr[s]);
        end
        if (s_wvalid[s] && s_wready[s]) begin
          s_w_q[s].push_back({s_wdata[s], s_wstrb[s]});
        end
        while (s_aw_q[s].size() > 0 && s_w_q[s].size() > 0) begin
          a = s_aw_q[s].pop_front();
          w = s_w_q[s].pop_front();
          got = {a, w};
          assert (exp_q[s].size() > 0 && exp_q[s][0] == got) else begin
            $display("FAIL %0t: out%0d got write %h, unexpected", $time, s, got);
            errors++;
          end
          if (exp_q[s].size() > 0) begin
            void'(exp_q[s].pop_front());
          end
          b_q[s].push_back(a);
        end
        if (s_bvalid[s] && s_bready[s]) begin
          void'(b_q[s].pop_front());
          b_taken[s] = 1'b1;
        end
      end
    end
  end

  // subordinate models with stalls capped at two cycles and b at least 8 cycles late
  always @(negedge axi_clk) begin
    for (int s = 0; s < 2; s++) begin
      if (!axi_resetn) begin
        s_awready[s] = 1'b0;
        s_wready[s] = 1'b0;
        s_bvalid[s] = 1'b0;
      end else begin
        s_awready[s] = (aw_stall[s] >= 2) || 1'($random(seed));
        aw_stall[s] = s_awready[s] ? 0 : aw_stall[s] + 1;
        s_wready[s] = (w_stall[s] >= 2) || 1'($random(seed));
        w_stall[s] = s_wready[s] ? 0 : w_stall[s] + 1;
        if (b_taken[s]) begin
          s_bvalid[s] = 1'b0;
          b_taken[s] = 1'b0;
          b_wait[s] = 8 + $unsigned($random(seed)) % 4;
        end else if (!s_bvalid[s] && b_q[s].size() > 0) begin
          if (b_wait[s] == 0) begin
            s_bvalid[s] = 1'b1;
            s_bresp[s] = b_q[s][0][2:1];
          end else begin
            b_wait[s]--;
          end
        end
      end
    end
  end

  initial begin
    int start;
    axi_clk = 1'b0;
    axi_resetn = 1'b0;
    m_awvalid = '0;
    m_wvalid = '0;
    m_bready = '0;
    s_awready = '0;
    s_wready = '0;
    s_bvalid = '0;
    for (int m = 0; m < 3; m++) begin
      m_awaddr[m] = '0;
      m_wdata[m] = '0;
      m_wstrb[m] = '0;
    end
    for (int s = 0; s < 2; s++) begin
      s_bresp[s] = '0;
      b_wait[s] = 8;
    end
    errors = 0;
    tests = 0;

    start = errors;
    @(posedge axi_clk);
    // managers request toward both subordinates from the second reset cycle on
    @(negedge axi_clk);
    for (int m = 0; m < 3; m++) begin
      m_awaddr[m] = 20'(m);
    end
    m_awvalid = '1;
    m_wvalid = '1;
    m_bready = '1;
    repeat (9) @(posedge axi_clk);
    @(negedge axi_clk);
    axi_resetn = 1'b1;
    m_awvalid = '0;
    m_wvalid = '0;
    m_bready = '0;
    end_test("reset", start);

    start = errors;
    fork
      run_manager(0, 6, 2);
      run_manager(1, 6, 2);
      run_manager(2, 6, 2);
    join
    end_test("routing", start);

    start = errors;
    fork
      run_manager(0, 10, 0);
      run_manager(1, 10, 0);
      run_manager(2, 10, 0);
    join
    end_test("fairness", start);

    start = errors;
    fork
      run_manager(0, 15, 2);
      run_manager(1, 15, 2);
      run_manager(2, 15, 2);
    join
    end_test("backpressure", start);

    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- src.f
logic/axil_xbar_pkg.sv
logic/axil_write_if.sv
logic/resp_order_fifo.sv
logic/write_channel_arb.sv
logic/axil_write_xbar.sv
bench/axil_write_xbar_chk.sv
bench/axil_write_xbar_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f src.f --top-module axil_write_xbar_tb -Mdir obj_dir
out=$(./obj_dir/Vaxil_write_xbar_tb 2>&1) || true
echo "$out"
echo "$out" | grep -q "Simulation finished: PASS"
